/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addiu = 6'h09,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_t;

	typedef struct packed {
		opcode_t    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_t     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_t     op;
		logic [25:0] target; // Word index inside the current 256 MB region.
	} j_fmt_t;

	// Same word, read by whichever layout the opcode calls for.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

	localparam instr_t nop_word = '0; // sll $0, $0, 0.

endpackage

`default_nettype wire

/* verilog/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	localparam int reg_count = 32;
	localparam logic [31:0] retaddr_offset = 32'd8; // Skips the delay slot.
	localparam logic [31:0] pc_reset = 32'h0000_3000;
	localparam int im_addr_bits = 6;
	localparam int im_depth = 1 << im_addr_bits;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll, alu_lui
	} alu_op_t;

	typedef enum logic [1:0] {ext_zero, ext_sign, ext_upper} ext_mode_t;

	typedef enum logic [2:0] {jm_seq, jm_beq, jm_bne, jm_jump, jm_jr} jump_mode_t;

	typedef enum logic [1:0] {wb_alu, wb_load, wb_retaddr} wb_sel_t;

	typedef enum logic [2:0] {
		fwd_orig, fwd_e_ret, fwd_m_alu, fwd_m_ret, fwd_w_data
	} fwd_t;

	// Last stage in which an operand may still arrive.
	typedef enum logic [1:0] {need_d, need_e, need_m, need_none} need_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    alu_src; // Immediate as second operand.
	} ctrl_e_t;

	typedef struct packed {
		logic store;
	} ctrl_m_t;

	typedef struct packed {
		logic       write_enable;
		logic [4:0] dest;
		wb_sel_t    wb_sel;
	} ctrl_w_t;

	typedef struct packed {
		logic [31:0]     pc;
		isa_pkg::instr_t instr;
	} d_stage_t;

	typedef struct packed {
		logic [31:0]     pc;
		isa_pkg::instr_t instr;
		ctrl_e_t         ce;
		ctrl_m_t         cm;
		ctrl_w_t         cw;
		logic [31:0]     rs_val;
		logic [31:0]     rt_val;
		logic [31:0]     ext;
	} e_stage_t;

	typedef struct packed {
		logic [31:0]     pc;
		isa_pkg::instr_t instr;
		ctrl_m_t         cm;
		ctrl_w_t         cw;
		logic [31:0]     alu_result;
		logic [31:0]     rt_val;
	} m_stage_t;

	typedef struct packed {
		logic [31:0]     pc;
		isa_pkg::instr_t instr;
		ctrl_w_t         cw;
		logic [31:0]     alu_result;
		logic [31:0]     load_data;
	} w_stage_t;

endpackage

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu (
	input  logic [31:0]       num1,
	input  logic [31:0]       num2,
	input  logic [4:0]        shamt,
	input  pipe_pkg::alu_op_t op,
	output logic [31:0]       result
);
	import pipe_pkg::*;

	always_comb begin
		case (op)
			alu_add: result = num1 + num2;
			alu_sub: result = num1 - num2;
			alu_and: result = num1 & num2;
			alu_or: result = num1 | num2;
			alu_slt: result = {31'd0, $signed(num1) < $signed(num2)};
			alu_sll: result = num2 << shamt; // Shifts rt.
			alu_lui: result = num2; // Immediate already in the upper half.
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rf.sv */
`default_nettype none

module rf (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [$clog2(pipe_pkg::reg_count)-1:0] read_addr1,
	input  logic [$clog2(pipe_pkg::reg_count)-1:0] read_addr2,
	input  logic [$clog2(pipe_pkg::reg_count)-1:0] write_addr,
	input  logic [31:0]                            write_data,
	input  logic                                   write_enable,
	output logic [31:0]                            read_result1,
	output logic [31:0]                            read_result2
);
	import pipe_pkg::*;

	logic [31:0] regs [reg_count];

	always_ff @(posedge clk) begin
		if (!rst_n)
			regs[0] <= '0;
		else if (write_enable && write_addr != '0)
			regs[write_addr] <= write_data;
	end

	// Write in W is seen by a D read in the same cycle.
	assign read_result1 = (write_enable && write_addr != '0 && write_addr == read_addr1) ?
		write_data : regs[read_addr1];
	assign read_result2 = (write_enable && write_addr != '0 && write_addr == read_addr2) ?
		write_data : regs[read_addr2];

	assert property (@(posedge clk) disable iff (!rst_n)
		(read_addr1 == '0) |-> (read_result1 == '0));

	assert property (@(posedge clk) disable iff (!rst_n)
		(read_addr2 == '0) |-> (read_result2 == '0));

endmodule

`default_nettype wire

/* verilog/im.sv */
`default_nettype none

module im (
	input  logic [31:0]     addr,
	output isa_pkg::instr_t instr
);
	import pipe_pkg::*;

	logic [31:0] rom [im_depth];
	logic [im_addr_bits-1:0] word_index;

	initial
		$readmemh("program.hex", rom);

	assign word_index = im_addr_bits'((addr - pc_reset) >> 2);
	assign instr = rom[word_index];

endmodule

`default_nettype wire

/* verilog/control.sv */
`default_nettype none

module control (
	input  logic                 clk,
	input  logic                 rst_n,
	input  isa_pkg::instr_t      d_instr,
	input  isa_pkg::instr_t      e_instr,
	input  isa_pkg::instr_t      m_instr,
	input  isa_pkg::instr_t      w_instr,
	output logic                 pc_enable,
	output logic                 d_enable,
	output logic                 e_flush,
	output pipe_pkg::jump_mode_t jump_mode,
	output pipe_pkg::ext_mode_t  ext_mode,
	output pipe_pkg::ctrl_e_t    d_ctrl_e,
	output pipe_pkg::ctrl_m_t    d_ctrl_m,
	output pipe_pkg::ctrl_w_t    d_ctrl_w,
	output logic [4:0]           rf_read_addr1,
	output logic [4:0]           rf_read_addr2,
	output pipe_pkg::fwd_t       fwd_d1,
	output pipe_pkg::fwd_t       fwd_d2,
	output pipe_pkg::fwd_t       fwd_e1,
	output pipe_pkg::fwd_t       fwd_e2,
	output pipe_pkg::fwd_t       fwd_m
);
	import isa_pkg::*;
	import pipe_pkg::*;

	ctrl_w_t e_w, m_w, w_w;
	need_t need_rs, need_rt;
	logic stall;

	function automatic ctrl_w_t dest_of(instr_t ins);
		ctrl_w_t cw;
		cw = '0;
		case (ins.r.op)
			op_rtype:
				case (ins.r.funct)
					fn_addu, fn_subu, fn_and, fn_or, fn_slt, fn_sll: begin
						cw.write_enable = 1'b1;
						cw.dest = ins.r.rd;
					end
					default: ;
				endcase
			op_addiu, op_ori, op_lui: begin
				cw.write_enable = 1'b1;
				cw.dest = ins.i.rt;
			end
			op_lw: begin
				cw.write_enable = 1'b1;
				cw.dest = ins.i.rt;
				cw.wb_sel = wb_load;
			end
			op_jal: begin
				cw.write_enable = 1'b1;
				cw.dest = 5'd31; // Link register.
				cw.wb_sel = wb_retaddr;
			end
			default: ;
		endcase
		if (cw.dest == 5'd0)
			cw.write_enable = 1'b0; // Writes to $0 are dropped.
		return cw;
	endfunction

	function automatic logic hits(ctrl_w_t p, logic [4:0] r);
		return p.write_enable && p.dest == r;
	endfunction

	// Newest producer wins, even if its value is not ready yet.
	function automatic fwd_t pick(logic [4:0] r, ctrl_w_t pe, ctrl_w_t pm, ctrl_w_t pw);
		if (hits(pe, r))
			return (pe.wb_sel == wb_retaddr) ? fwd_e_ret : fwd_orig;
		if (hits(pm, r)) begin
			if (pm.wb_sel == wb_alu)
				return fwd_m_alu;
			if (pm.wb_sel == wb_retaddr)
				return fwd_m_ret;
			return fwd_orig; // Load; corrected one stage later.
		end
		if (hits(pw, r))
			return fwd_w_data;
		return fwd_orig;
	endfunction

	// Cycles until a producer's value can be forwarded, against when it is needed.
	function automatic logic late(logic [4:0] r, need_t need, ctrl_w_t pe, ctrl_w_t pm);
		logic [1:0] ready_e, ready_m;
		ready_e = (pe.wb_sel == wb_load) ? 2'd2 : (pe.wb_sel == wb_alu) ? 2'd1 : 2'd0;
		ready_m = (pm.wb_sel == wb_load) ? 2'd1 : 2'd0;
		if (hits(pe, r))
			return ready_e > need;
		if (hits(pm, r))
			return ready_m > need;
		return 1'b0;
	endfunction

	always_comb begin
		d_ctrl_e = '0;
		d_ctrl_m = '0;
		jump_mode = jm_seq;
		ext_mode = ext_sign;
		need_rs = need_none;
		need_rt = need_none;
		case (d_instr.r.op)
			op_rtype: begin
				need_rs = need_e;
				need_rt = need_e;
				case (d_instr.r.funct)
					fn_subu: d_ctrl_e.alu_op = alu_sub;
					fn_and: d_ctrl_e.alu_op = alu_and;
					fn_or: d_ctrl_e.alu_op = alu_or;
					fn_slt: d_ctrl_e.alu_op = alu_slt;
					fn_sll: begin
						d_ctrl_e.alu_op = alu_sll;
						need_rs = need_none;
					end
					fn_jr: begin
						jump_mode = jm_jr;
						need_rs = need_d;
						need_rt = need_none;
					end
					default: ; // addu keeps alu_add.
				endcase
			end
			op_addiu, op_lw: begin
				d_ctrl_e.alu_src = 1'b1;
				need_rs = need_e;
			end
			op_ori: begin
				d_ctrl_e = '{alu_op: alu_or, alu_src: 1'b1};
				ext_mode = ext_zero;
				need_rs = need_e;
			end
			op_lui: begin
				d_ctrl_e = '{alu_op: alu_lui, alu_src: 1'b1};
				ext_mode = ext_upper;
			end
			op_sw: begin
				d_ctrl_e.alu_src = 1'b1;
				d_ctrl_m.store = 1'b1;
				need_rs = need_e;
				need_rt = need_m; // Store data is only read in M.
			end
			op_beq, op_bne: begin
				jump_mode = (d_instr.r.op == op_beq) ? jm_beq : jm_bne;
				need_rs = need_d;
				need_rt = need_d;
			end
			op_j, op_jal: jump_mode = jm_jump;
			default: ;
		endcase
	end

	assign d_ctrl_w = dest_of(d_instr);
	assign e_w = dest_of(e_instr);
	assign m_w = dest_of(m_instr);
	assign w_w = dest_of(w_instr);

	assign rf_read_addr1 = d_instr.r.rs;
	assign rf_read_addr2 = d_instr.r.rt;

	assign stall = late(d_instr.r.rs, need_rs, e_w, m_w) || late(d_instr.r.rt, need_rt, e_w, m_w);
	assign pc_enable = !stall;
	assign d_enable = !stall;
	assign e_flush = stall;

	assign fwd_d1 = pick(d_instr.r.rs, e_w, m_w, w_w);
	assign fwd_d2 = pick(d_instr.r.rt, e_w, m_w, w_w);
	assign fwd_e1 = pick(e_instr.r.rs, ctrl_w_t'('0), m_w, w_w);
	assign fwd_e2 = pick(e_instr.r.rt, ctrl_w_t'('0), m_w, w_w);
	assign fwd_m = pick(m_instr.r.rt, ctrl_w_t'('0), ctrl_w_t'('0), w_w);

	// A load feeding a branch holds the PC twice, never longer.
	assert property (@(posedge clk) disable iff (!rst_n)
		(stall && $past(stall)) |=> !stall);

	assert property (@(posedge clk) disable iff (!rst_n)
		(fwd_d1 != fwd_orig) |-> (d_instr.r.rs != 5'd0));

	assert property (@(posedge clk) disable iff (!rst_n)
		(fwd_e2 != fwd_orig) |-> (e_instr.r.rt != 5'd0));

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`default_nettype none

module cpu (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] cpu_read_result,
	output logic [31:0] cpu_addr,
	output logic [31:0] cpu_write_data,
	output logic        dev_write_enable
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [31:0] pc, next_pc, d_seq_pc, br_target;
	instr_t f_instr;
	d_stage_t d_q;
	e_stage_t e_q;
	m_stage_t m_q;
	w_stage_t w_q;

	logic pc_enable, d_enable, e_flush;
	jump_mode_t jump_mode;
	ext_mode_t ext_mode;
	ctrl_e_t d_ctrl_e;
	ctrl_m_t d_ctrl_m;
	ctrl_w_t d_ctrl_w;
	logic [4:0] rf_read_addr1, rf_read_addr2;
	fwd_t fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m;

	logic [31:0] rd1, rd2, d_rs, d_rt, d_ext;
	logic [31:0] e_rs, e_rt, e_ret, alu_num2, alu_result;
	logic [31:0] m_rt, m_ret, w_ret, w_data;

	function automatic logic [31:0] fwd_value(fwd_t sel, logic [31:0] orig);
		case (sel)
			fwd_e_ret: return e_ret;
			fwd_m_alu: return m_q.alu_result;
			fwd_m_ret: return m_ret;
			fwd_w_data: return w_data;
			default: return orig;
		endcase
	endfunction

	control control (
		.clk(clk), .rst_n(rst_n),
		.d_instr(d_q.instr), .e_instr(e_q.instr), .m_instr(m_q.instr), .w_instr(w_q.instr),
		.pc_enable(pc_enable), .d_enable(d_enable), .e_flush(e_flush),
		.jump_mode(jump_mode), .ext_mode(ext_mode),
		.d_ctrl_e(d_ctrl_e), .d_ctrl_m(d_ctrl_m), .d_ctrl_w(d_ctrl_w),
		.rf_read_addr1(rf_read_addr1), .rf_read_addr2(rf_read_addr2),
		.fwd_d1(fwd_d1), .fwd_d2(fwd_d2), .fwd_e1(fwd_e1), .fwd_e2(fwd_e2), .fwd_m(fwd_m)
	);

	rf rf (
		.clk(clk), .rst_n(rst_n),
		.read_addr1(rf_read_addr1), .read_addr2(rf_read_addr2),
		.write_addr(w_q.cw.dest), .write_data(w_data), .write_enable(w_q.cw.write_enable),
		.read_result1(rd1), .read_result2(rd2)
	);

	im im (.addr(pc), .instr(f_instr));

	alu alu (.num1(e_rs), .num2(alu_num2), .shamt(e_q.instr.r.shamt), .op(e_q.ce.alu_op),
		.result(alu_result));

	assign e_ret = e_q.pc + retaddr_offset;
	assign m_ret = m_q.pc + retaddr_offset;
	assign w_ret = w_q.pc + retaddr_offset;

	always_comb begin
		d_rs = fwd_value(fwd_d1, rd1);
		d_rt = fwd_value(fwd_d2, rd2);
		e_rs = fwd_value(fwd_e1, e_q.rs_val);
		e_rt = fwd_value(fwd_e2, e_q.rt_val);
		m_rt = fwd_value(fwd_m, m_q.rt_val); // Store data.
	end

	assign d_seq_pc = d_q.pc + 32'd4;
	assign br_target = d_seq_pc + {{14{d_q.instr.i.imm[15]}}, d_q.instr.i.imm, 2'b00};

	// Branches resolve in D; F already holds the delay slot.
	always_comb begin
		case (jump_mode)
			jm_beq: next_pc = (d_rs == d_rt) ? br_target : pc + 32'd4;
			jm_bne: next_pc = (d_rs != d_rt) ? br_target : pc + 32'd4;
			jm_jump: next_pc = {d_seq_pc[31:28], d_q.instr.j.target, 2'b00};
			jm_jr: next_pc = d_rs;
			default: next_pc = pc + 32'd4;
		endcase
	end

	always_comb begin
		case (ext_mode)
			ext_zero: d_ext = {16'h0000, d_q.instr.i.imm};
			ext_upper: d_ext = {d_q.instr.i.imm, 16'h0000};
			default: d_ext = {{16{d_q.instr.i.imm[15]}}, d_q.instr.i.imm};
		endcase
	end

	assign alu_num2 = e_q.ce.alu_src ? e_q.ext : e_rt;

	always_comb begin
		case (w_q.cw.wb_sel)
			wb_load: w_data = w_q.load_data;
			wb_retaddr: w_data = w_ret;
			default: w_data = w_q.alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= pc_reset;
		else if (pc_enable)
			pc <= next_pc;
	end

	always_ff @(posedge clk) begin
		if (d_enable) begin
			d_q.pc <= pc;
			d_q.instr <= f_instr;
		end
		if (!rst_n)
			d_q.instr <= nop_word;
	end

	always_ff @(posedge clk) begin
		e_q.pc <= d_q.pc;
		e_q.instr <= d_q.instr;
		e_q.ce <= d_ctrl_e;
		e_q.cm <= d_ctrl_m;
		e_q.cw <= d_ctrl_w;
		e_q.rs_val <= d_rs;
		e_q.rt_val <= d_rt;
		e_q.ext <= d_ext;
		if (!rst_n || e_flush) begin // Bubble.
			e_q.instr <= nop_word;
			e_q.cm <= '0;
			e_q.cw <= '0;
		end
	end

	always_ff @(posedge clk) begin
		m_q.pc <= e_q.pc;
		m_q.instr <= e_q.instr;
		m_q.cm <= e_q.cm;
		m_q.cw <= e_q.cw;
		m_q.alu_result <= alu_result;
		m_q.rt_val <= e_rt;
		if (!rst_n) begin
			m_q.instr <= nop_word;
			m_q.cm <= '0;
			m_q.cw <= '0;
		end
	end

	always_ff @(posedge clk) begin
		w_q.pc <= m_q.pc;
		w_q.instr <= m_q.instr;
		w_q.cw <= m_q.cw;
		w_q.alu_result <= m_q.alu_result;
		w_q.load_data <= cpu_read_result; // Device answers in the same cycle.
		if (!rst_n) begin
			w_q.instr <= nop_word;
			w_q.cw <= '0;
		end
	end

	assign cpu_addr = m_q.alu_result;
	assign cpu_write_data = m_rt;
	assign dev_write_enable = m_q.cm.store;

	assert property (@(posedge clk) disable iff (!rst_n)
		dev_write_enable |-> cpu_addr[1:0] == 2'b00)
		else $error("store to unaligned address %h", cpu_addr);

endmodule

`default_nettype wire

/* bench/cpu_tb.sv */
`default_nettype none

module cpu_tb;

	localparam int prog_words = 33;
	localparam int cycle_limit = 4 * prog_words + 40;
	localparam int drain_cycles = 16;
	localparam int store_count = 11;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] value;    // Constant, or offset added to a loaded word.
		logic        from_mem;
		logic [31:0] src_addr; // Word the program loaded earlier.
	} store_t;

	logic clk;
	logic rst_n;
	logic [31:0] cpu_read_result;
	logic [31:0] cpu_addr;
	logic [31:0] cpu_write_data;
	logic dev_write_enable;

	logic [31:0] mem [16];
	logic [31:0] init_mem [16];
	store_t stores [store_count];
	int store_idx;
	int errors;
	int cycles;
	int reset_errors;

	cpu UUT (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_read_result(cpu_read_result),
		.cpu_addr(cpu_addr),
		.cpu_write_data(cpu_write_data),
		.dev_write_enable(dev_write_enable)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // Taps 32, 22, 2, 1.
		return {s[30:0], fb};
	endfunction

	function automatic store_t entry(input logic [31:0] addr, input logic [31:0] value,
		input logic from_mem, input logic [31:0] src_addr);
		store_t e;
		e.addr = addr;
		e.value = value;
		e.from_mem = from_mem;
		e.src_addr = src_addr;
		return e;
	endfunction

	task automatic fill_memory();
		logic [31:0] state;
		logic [31:0] word;
		state = 32'd75095;
		word = '0;
		for (int i = 0; i < 16; i++) begin
			for (int b = 0; b < 32; b++) begin
				state = lfsr_next(state);
				word = {word[30:0], state[0]};
			end
			mem[i] = word;
			init_mem[i] = word;
		end
	endtask

	// Expected stores in program order, worked out from the instruction semantics.
	task automatic load_table();
		logic [31:0] r1, r2, r3, r4, r5, r6, r7, r10, r31;
		r1 = 32'h0000_1234;
		r2 = {16'habcd, 16'h0000};
		r3 = r1 + r2;
		r4 = r3 - r1;
		r5 = ($signed(r4) < $signed(r1)) ? 32'd1 : 32'd0;
		r6 = r1 << 4;
		r7 = r6 & r3;
		r10 = 32'h0000_0055;
		r31 = 32'h0000_304c + 32'd8; // The jal sits at 0x304c.
		stores[0] = entry(32'h00, r3, 1'b0, '0);
		stores[1] = entry(32'h04, r4, 1'b0, '0);
		stores[2] = entry(32'h08, r5, 1'b0, '0);
		stores[3] = entry(32'h0c, r7, 1'b0, '0);
		stores[4] = entry(32'h14, 32'd5, 1'b1, 32'h10); // Load then addiu at once.
		stores[5] = entry(32'h18, r1, 1'b0, '0);  // Taken beq delay slot.
		stores[6] = entry(32'h1c, r2, 1'b0, '0);  // Untaken bne delay slot.
		stores[7] = entry(32'h24, r31, 1'b0, '0);
		stores[8] = entry(32'h28, r1, 1'b0, '0);  // jr delay slot.
		stores[9] = entry(32'h20, r10, 1'b0, '0); // Return target of jal.
		stores[10] = entry(32'h2c, r3, 1'b0, '0); // beq after a load.
	endtask

	task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input int idx);
		if (got !== exp) begin
			$display("mismatch at %0t: store %0d address %h, expected %h", $time, idx, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input int idx);
		if (got !== exp) begin
			$display("mismatch at %0t: store %0d data %h, expected %h", $time, idx, got, exp);
			errors++;
		end
	endtask

	task automatic check_strobe(input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: write strobe %b during reset, expected %b",
				$time, got, exp);
			errors++;
		end
	endtask

	// Called on each falling edge, where the memory-stage outputs are settled.
	task automatic serve_bus();
		store_t exp;
		logic [31:0] exp_data;
		int errs_before;
		cycles++;
		if (dev_write_enable === 1'b1) begin
			if (store_idx < store_count) begin
				exp = stores[store_idx];
				exp_data = exp.from_mem ? init_mem[exp.src_addr[5:2]] + exp.value : exp.value;
				errs_before = errors;
				check_addr(cpu_addr, exp.addr, store_idx);
				check_data(cpu_write_data, exp_data, store_idx);
				$display("store %0d: addr %h data %h %s", store_idx, cpu_addr, cpu_write_data,
					(errors == errs_before) ? "ok" : "FAILED");
				store_idx++;
			end else begin
				$display("unexpected store at %0t: addr %h data %h",
					$time, cpu_addr, cpu_write_data);
				errors++;
			end
			mem[cpu_addr[5:2]] = cpu_write_data;
		end
		cpu_read_result = mem[cpu_addr[5:2]]; // Sampled by W at the next rising edge.
	endtask

	initial begin
		rst_n = 1'b0;
		cpu_read_result = '0;
		store_idx = 0;
		errors = 0;
		cycles = 0;
		fill_memory();
		load_table();
		repeat (4) begin
			@(negedge clk);
			check_strobe(dev_write_enable, 1'b0);
		end
		reset_errors = errors;
		$display("reset: write strobe low %s", (reset_errors == 0) ? "ok" : "FAILED");
		rst_n = 1'b1;
		while (store_idx < store_count && cycles < cycle_limit) begin
			@(negedge clk);
			serve_bus();
		end
		if (store_idx < store_count) begin
			$display("timeout: only %0d of %0d stores seen after %0d cycles",
				store_idx, store_count, cycles);
			errors++;
		end
		// A few more cycles so that a stray store after the last one is caught.
		repeat (drain_cycles) begin
			@(negedge clk);
			serve_bus();
		end
		$display("stores seen %0d of %0d, errors %0d", store_idx, store_count, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* program.hex */
// One 32-bit instruction word per line, in program order from address 0x3000.
34011234
3c02abcd
00221821
ac030000
00612023
0081282a
ac040004
ac050008
00013100
00c33824
ac07000c
8c080010
25090005
ac090014
10210002
ac010018
ac00001c
14210001
ac02001c
0c000c18
340a0055
ac0a0020
08000c1c
00000000
ac1f0024
03e00008
ac010028
ac00002c
8c0b0000
11630001
ac0b002c
08000c1f
00000000

/* all.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/alu.sv
verilog/rf.sv
verilog/im.sv
verilog/control.sv
verilog/cpu.sv
bench/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module cpu_tb -o cpu_sim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/cpu_sim | tee sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
